// ==== mc_sys_consts.svh ====
`ifndef MC_SYS_CONSTS_SVH
`define MC_SYS_CONSTS_SVH

// Bus widths
`define MC_ADDR_W 32
`define MC_DATA_W 32
`define MC_STRB_W 4

// Device windows of 1 kB each
`define MC_RAM_BASE     32'h0010_0000
`define MC_SIMCTRL_BASE 32'h0002_0000
`define MC_TIMER_BASE   32'h0003_0000
`define MC_WIN_MASK     32'hFFFF_FC00

// Scratch RAM depth in 32-bit words
`define MC_RAM_WORDS 256

// Word offset inside a window
`define MC_OFF_W 8

// Simulation-control register offsets
`define MC_SC_CHAR 8'd0
`define MC_SC_HALT 8'd1

// Timer register offsets
`define MC_TM_LO     8'd0
`define MC_TM_HI     8'd1
`define MC_TM_CMP_LO 8'd2
`define MC_TM_CMP_HI 8'd3

`endif

// ==== mc_sys_pkg.sv ====
`default_nettype none

`include "mc_sys_consts.svh"

package mc_sys_pkg;

  // AXI4-Lite response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Host to slave
  typedef struct packed {
    logic                  aw_valid;
    logic [`MC_ADDR_W-1:0] aw_addr;
    logic                  w_valid;
    logic [`MC_DATA_W-1:0] w_data;
    logic [`MC_STRB_W-1:0] w_strb;
    logic                  b_ready;
    logic                  ar_valid;
    logic [`MC_ADDR_W-1:0] ar_addr;
    logic                  r_ready;
  } axil_req_t;

  // Slave to host
  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    axil_resp_e            b_resp;
    logic                  ar_ready;
    logic                  r_valid;
    logic [`MC_DATA_W-1:0] r_data;
    axil_resp_e            r_resp;
  } axil_rsp_t;

  // One access on the device side
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [`MC_STRB_W-1:0] be;
    logic [`MC_OFF_W-1:0]  off;
    logic [`MC_DATA_W-1:0] wdata;
  } dev_req_t;

  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_SIMCTRL,
    DEV_TIMER,
    DEV_NONE
  } bus_device_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ,
    ST_BRESP,
    ST_RRESP
  } bus_state_e;

endpackage

`default_nettype wire

// ==== mc_bus_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_sys_consts.svh"

module mc_bus_fsm (
  input  logic                  clk_sys,
  input  logic                  arst_n_i,
  input  mc_sys_pkg::axil_req_t axil_req_i,
  output mc_sys_pkg::axil_rsp_t axil_rsp_o,
  output mc_sys_pkg::dev_req_t  ram_req_o,
  output mc_sys_pkg::dev_req_t  sc_req_o,
  output mc_sys_pkg::dev_req_t  tm_req_o,
  input  logic [`MC_DATA_W-1:0] ram_rdata_i,
  input  logic [`MC_DATA_W-1:0] sc_rdata_i,
  input  logic [`MC_DATA_W-1:0] tm_rdata_i
);

  import mc_sys_pkg::*;

  bus_state_e            state_q;
  bus_state_e            state_d;
  bus_device_e           dev_q;
  logic [`MC_OFF_W-1:0]  off_q;
  logic [`MC_DATA_W-1:0] wdata_q;
  logic [`MC_STRB_W-1:0] strb_q;
  logic                  wr_hs;
  logic                  rd_hs;
  dev_req_t              acc_req;

  // Map an address onto one of the device windows
  function automatic bus_device_e decode(input logic [`MC_ADDR_W-1:0] addr);
    bus_device_e dev;
    dev = DEV_NONE;
    if ((addr & `MC_WIN_MASK) == `MC_RAM_BASE) begin
      dev = DEV_RAM;
    end else if ((addr & `MC_WIN_MASK) == `MC_SIMCTRL_BASE) begin
      dev = DEV_SIMCTRL;
    end else if ((addr & `MC_WIN_MASK) == `MC_TIMER_BASE) begin
      dev = DEV_TIMER;
    end
    return dev;
  endfunction

  // Writes need both channels and even a half-presented write blocks reads
  assign wr_hs = (state_q == ST_IDLE) && axil_req_i.aw_valid && axil_req_i.w_valid;
  assign rd_hs = (state_q == ST_IDLE) && !axil_req_i.aw_valid && !axil_req_i.w_valid &&
                 axil_req_i.ar_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (wr_hs) begin
          state_d = ST_WRITE;
        end else if (rd_hs) begin
          state_d = ST_READ;
        end
      end
      ST_WRITE: state_d = ST_BRESP;
      ST_READ:  state_d = ST_RRESP;
      ST_BRESP: begin
        if (axil_req_i.b_ready) begin
          state_d = ST_IDLE;
        end
      end
      ST_RRESP: begin
        if (axil_req_i.r_ready) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      dev_q   <= DEV_NONE;
    end else begin
      state_q <= state_d;
      if (wr_hs) begin
        dev_q <= decode(axil_req_i.aw_addr);
      end else if (rd_hs) begin
        dev_q <= decode(axil_req_i.ar_addr);
      end
    end
  end

  // Accepted offset and write payload
  always_ff @(posedge clk_sys) begin
    if (wr_hs) begin
      off_q   <= axil_req_i.aw_addr[`MC_OFF_W+1:2];
      wdata_q <= axil_req_i.w_data;
      strb_q  <= axil_req_i.w_strb;
    end else if (rd_hs) begin
      off_q <= axil_req_i.ar_addr[`MC_OFF_W+1:2];
    end
  end

  // One request steered to the decoded device only
  always_comb begin
    acc_req.req   = (state_q == ST_WRITE) || (state_q == ST_READ);
    acc_req.we    = (state_q == ST_WRITE);
    acc_req.be    = strb_q;
    acc_req.off   = off_q;
    acc_req.wdata = wdata_q;

    ram_req_o     = acc_req;
    ram_req_o.req = acc_req.req && (dev_q == DEV_RAM);
    sc_req_o      = acc_req;
    sc_req_o.req  = acc_req.req && (dev_q == DEV_SIMCTRL);
    tm_req_o      = acc_req;
    tm_req_o.req  = acc_req.req && (dev_q == DEV_TIMER);
  end

  always_comb begin
    axil_rsp_o          = '0;
    axil_rsp_o.aw_ready = wr_hs;
    axil_rsp_o.w_ready  = wr_hs;
    axil_rsp_o.ar_ready = rd_hs;
    axil_rsp_o.b_valid  = (state_q == ST_BRESP);
    axil_rsp_o.r_valid  = (state_q == ST_RRESP);
    axil_rsp_o.b_resp   = (dev_q == DEV_NONE) ? DECERR : OKAY;
    axil_rsp_o.r_resp   = (dev_q == DEV_NONE) ? DECERR : OKAY;
    // Device read registers hold until the next read request
    case (dev_q)
      DEV_RAM:     axil_rsp_o.r_data = ram_rdata_i;
      DEV_SIMCTRL: axil_rsp_o.r_data = sc_rdata_i;
      DEV_TIMER:   axil_rsp_o.r_data = tm_rdata_i;
      default:     axil_rsp_o.r_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== mc_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_sys_consts.svh"

module mc_timer (
  input  logic                  clk_sys,
  input  logic                  arst_n_i,
  input  mc_sys_pkg::dev_req_t  req_i,
  output logic [`MC_DATA_W-1:0] rdata_o,
  output logic                  timer_irq_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        wr;
  logic        rd;

  assign wr = req_i.req && req_i.we;
  assign rd = req_i.req && !req_i.we;

  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      mtime_q <= mtime_q + 64'd1;
      // A half write overrides the increment of that half
      if (wr) begin
        case (req_i.off)
          `MC_TM_LO:     mtime_q[31:0]     <= req_i.wdata;
          `MC_TM_HI:     mtime_q[63:32]    <= req_i.wdata;
          `MC_TM_CMP_LO: mtimecmp_q[31:0]  <= req_i.wdata;
          `MC_TM_CMP_HI: mtimecmp_q[63:32] <= req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  // Read data held until the next read
  always_ff @(posedge clk_sys) begin
    if (rd) begin
      case (req_i.off)
        `MC_TM_LO:     rdata_o <= mtime_q[31:0];
        `MC_TM_HI:     rdata_o <= mtime_q[63:32];
        `MC_TM_CMP_LO: rdata_o <= mtimecmp_q[31:0];
        `MC_TM_CMP_HI: rdata_o <= mtimecmp_q[63:32];
        default:       rdata_o <= '0;
      endcase
    end
  end

  // Level interrupt
  assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// ==== mc_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_sys_consts.svh"

module mc_ram (
  input  logic                  clk_sys,
  input  mc_sys_pkg::dev_req_t  req_i,
  output logic [`MC_DATA_W-1:0] rdata_o
);

  logic [`MC_DATA_W-1:0] mem [`MC_RAM_WORDS];

  always_ff @(posedge clk_sys) begin
    if (req_i.req) begin
      if (req_i.we) begin
        // Byte lanes
        for (int i = 0; i < `MC_STRB_W; i++) begin
          if (req_i.be[i]) begin
            mem[req_i.off][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem[req_i.off];
      end
    end
  end

endmodule

`default_nettype wire

// ==== mc_sim_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_sys_consts.svh"

module mc_sim_ctrl (
  input  logic                  clk_sys,
  input  logic                  arst_n_i,
  input  mc_sys_pkg::dev_req_t  req_i,
  output logic [`MC_DATA_W-1:0] rdata_o,
  output logic                  char_valid_o,
  output logic [7:0]            char_o,
  output logic                  halt_o
);

  logic [31:0] char_cnt_q;
  logic        char_wr;
  logic        halt_wr;

  assign char_wr = req_i.req && req_i.we && (req_i.off == `MC_SC_CHAR);
  assign halt_wr = req_i.req && req_i.we && (req_i.off == `MC_SC_HALT);

  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      char_valid_o <= 1'b0;
      char_cnt_q   <= '0;
      halt_o       <= 1'b0;
    end else begin
      char_valid_o <= char_wr;
      if (char_wr) begin
        char_cnt_q <= char_cnt_q + 32'd1;
      end
      // Sticky until reset
      if (halt_wr && req_i.wdata[0]) begin
        halt_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (char_wr) begin
      char_o <= req_i.wdata[7:0];
    end
    if (req_i.req && !req_i.we) begin
      case (req_i.off)
        `MC_SC_CHAR: rdata_o <= char_cnt_q;
        `MC_SC_HALT: rdata_o <= {31'd0, halt_o};
        default:     rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== mc_sys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_sys_consts.svh"

module mc_sys_top (
  input  logic                  clk_sys,
  input  logic                  arst_n_i,
  input  mc_sys_pkg::axil_req_t axil_req_i,
  output mc_sys_pkg::axil_rsp_t axil_rsp_o,
  output logic                  char_valid_o,
  output logic [7:0]            char_o,
  output logic                  halt_o,
  output logic                  timer_irq_o
);

  import mc_sys_pkg::*;

  // Device side of the bus
  dev_req_t              ram_req;
  dev_req_t              sc_req;
  dev_req_t              tm_req;
  logic [`MC_DATA_W-1:0] ram_rdata;
  logic [`MC_DATA_W-1:0] sc_rdata;
  logic [`MC_DATA_W-1:0] tm_rdata;

  mc_bus_fsm u_bus_fsm (
    .clk_sys     (clk_sys),
    .arst_n_i    (arst_n_i),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .ram_req_o   (ram_req),
    .sc_req_o    (sc_req),
    .tm_req_o    (tm_req),
    .ram_rdata_i (ram_rdata),
    .sc_rdata_i  (sc_rdata),
    .tm_rdata_i  (tm_rdata)
  );

  // Scratch memory
  mc_ram u_ram (
    .clk_sys (clk_sys),
    .req_i   (ram_req),
    .rdata_o (ram_rdata)
  );

  mc_sim_ctrl u_sim_ctrl (
    .clk_sys      (clk_sys),
    .arst_n_i     (arst_n_i),
    .req_i        (sc_req),
    .rdata_o      (sc_rdata),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  mc_timer u_timer (
    .clk_sys     (clk_sys),
    .arst_n_i    (arst_n_i),
    .req_i       (tm_req),
    .rdata_o     (tm_rdata),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

// ==== tb_mc_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mc_sys_consts.svh"

module tb_mc_sys;

  import mc_sys_pkg::*;

  localparam int CLK_NS    = 4;
  localparam int N_RAM_OPS = 200;
  localparam int N_BAD     = 10;
  localparam int N_CHARS   = 8;
  // Bus operations of all sections plus slack for the timer wait
  localparam int OPS_TOTAL = N_RAM_OPS + 2 * N_BAD + N_CHARS + 30;

  logic        clk_sys;
  logic        arst_n_i;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        char_valid;
  logic [7:0]  char_data;
  logic        halt;
  logic        timer_irq;
  int unsigned cyc = 0;

  // System model
  logic [`MC_DATA_W-1:0] ram_model [`MC_RAM_WORDS];
  logic [`MC_STRB_W-1:0] ram_vld [`MC_RAM_WORDS];
  logic [7:0]            exp_chars [$];

  mc_sys_top u_dut (
    .clk_sys      (clk_sys),
    .arst_n_i     (arst_n_i),
    .axil_req_i   (axil_req),
    .axil_rsp_o   (axil_rsp),
    .char_valid_o (char_valid),
    .char_o       (char_data),
    .halt_o       (halt),
    .timer_irq_o  (timer_irq)
  );

  always #(CLK_NS / 2) clk_sys = ~clk_sys;

  always @(posedge clk_sys) begin
    cyc <= cyc + 1;
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
    if (got != exp) begin
      fail_stop($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input logic [`MC_DATA_W-1:0] got,
                            input logic [`MC_DATA_W-1:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_char(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  function automatic logic [`MC_ADDR_W-1:0] reg_addr(input logic [`MC_ADDR_W-1:0] base,
                                                     input logic [`MC_OFF_W-1:0] off);
    return base + {22'd0, off, 2'b00};
  endfunction

  function automatic logic [`MC_DATA_W-1:0] lane_mask(input logic [`MC_STRB_W-1:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  function automatic bit in_window(input logic [`MC_ADDR_W-1:0] a);
    logic [`MC_ADDR_W-1:0] w;
    w = a & `MC_WIN_MASK;
    return (w == `MC_RAM_BASE) || (w == `MC_SIMCTRL_BASE) || (w == `MC_TIMER_BASE);
  endfunction

  // Waits for B or R, holds ready off for a random time, checks the held payload
  task automatic take_resp(input bit is_read, output axil_resp_e resp,
                           output logic [`MC_DATA_W-1:0] data);
    int unsigned           delay;
    int unsigned           waited;
    bit                    seen;
    logic                  v;
    axil_resp_e            r;
    logic [`MC_DATA_W-1:0] d;
    delay  = $urandom_range(0, 3);
    waited = 0;
    seen   = 0;
    resp   = OKAY;
    data   = '0;
    forever begin
      @(negedge clk_sys);
      v = is_read ? axil_rsp.r_valid : axil_rsp.b_valid;
      r = is_read ? axil_rsp.r_resp : axil_rsp.b_resp;
      d = is_read ? axil_rsp.r_data : '0;
      if (seen && !v) begin
        fail_stop("response valid dropped before the host was ready");
      end
      if (seen && (r != resp || d !== data)) begin
        fail_stop("response payload changed while ready was low");
      end
      if (v && !seen) begin
        seen = 1;
        resp = r;
        data = d;
      end
      if (v && (is_read ? axil_req.r_ready : axil_req.b_ready)) begin
        break;
      end
      @(posedge clk_sys);
      #1;
      if (seen && waited >= delay) begin
        if (is_read) begin
          axil_req.r_ready = 1'b1;
        end else begin
          axil_req.b_ready = 1'b1;
        end
      end
      if (seen) begin
        waited++;
      end
    end
    @(posedge clk_sys);
    #1;
    axil_req.b_ready = 1'b0;
    axil_req.r_ready = 1'b0;
    @(negedge clk_sys);
    if (axil_rsp.b_valid || axil_rsp.r_valid) begin
      fail_stop("a second response followed a completed transfer");
    end
  endtask

  // AW and W raised after independent random delays
  task automatic axil_write(input logic [`MC_ADDR_W-1:0] addr, input logic [`MC_DATA_W-1:0] data,
                            input logic [`MC_STRB_W-1:0] strb, input axil_resp_e exp);
    int unsigned           aw_dly;
    int unsigned           w_dly;
    int unsigned           c;
    axil_resp_e            resp;
    logic [`MC_DATA_W-1:0] no_data;
    aw_dly = $urandom_range(0, 2);
    w_dly  = $urandom_range(0, 2);
    c      = 0;
    @(posedge clk_sys);
    #1;
    forever begin
      if (c >= aw_dly) begin
        axil_req.aw_valid = 1'b1;
        axil_req.aw_addr  = addr;
      end
      if (c >= w_dly) begin
        axil_req.w_valid = 1'b1;
        axil_req.w_data  = data;
        axil_req.w_strb  = strb;
      end
      @(negedge clk_sys);
      if (axil_rsp.aw_ready && axil_rsp.w_ready) begin
        break;
      end
      @(posedge clk_sys);
      #1;
      c++;
    end
    if (!(axil_req.aw_valid && axil_req.w_valid)) begin
      fail_stop("write accepted before both address and data were valid");
    end
    @(posedge clk_sys);
    #1;
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    take_resp(1'b0, resp, no_data);
    check_resp("b_resp", resp, exp);
  endtask

  task automatic axil_read(input logic [`MC_ADDR_W-1:0] addr, input axil_resp_e exp,
                           output logic [`MC_DATA_W-1:0] data);
    axil_resp_e resp;
    @(posedge clk_sys);
    #1;
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    @(negedge clk_sys);
    while (!axil_rsp.ar_ready) begin
      @(negedge clk_sys);
    end
    @(posedge clk_sys);
    #1;
    axil_req.ar_valid = 1'b0;
    take_resp(1'b1, resp, data);
    check_resp("r_resp", resp, exp);
  endtask

  // Character output in write order
  always @(negedge clk_sys) begin
    if (arst_n_i && char_valid) begin
      if (exp_chars.size() == 0) begin
        fail_stop("char_valid_o pulsed with no character written");
      end else begin
        check_char("char_o", char_data, exp_chars.pop_front());
      end
    end
  end

  initial begin
    #(OPS_TOTAL * 64 * CLK_NS);
    fail_stop("timeout: the run went past its time limit");
  end

  initial begin
    int unsigned           t0;
    int unsigned           elapsed;
    int unsigned           waited;
    logic [7:0]            idx;
    logic [7:0]            ch;
    logic [`MC_STRB_W-1:0] strb;
    logic [`MC_ADDR_W-1:0] addr;
    logic [`MC_DATA_W-1:0] wdata;
    logic [`MC_DATA_W-1:0] rdata;
    logic [`MC_DATA_W-1:0] mask;
    logic [`MC_DATA_W-1:0] v_hi;
    logic [`MC_DATA_W-1:0] v_lo;
    logic [31:0]           char_cnt;
    void'($urandom(55));
    clk_sys   = 1'b0;
    arst_n_i  = 1'b0;
    axil_req  = '0;
    ram_vld   = '{default: '0};
    char_cnt  = '0;
    repeat (10) @(posedge clk_sys);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_sys);
    if (axil_rsp.aw_ready || axil_rsp.w_ready || axil_rsp.b_valid || axil_rsp.ar_ready ||
        axil_rsp.r_valid || char_valid || halt || timer_irq) begin
      fail_stop("a ready, valid, char, halt or interrupt output is high after reset");
    end

    // Small index range so reads hit written words
    for (int n = 0; n < N_RAM_OPS; n++) begin
      idx  = 8'($urandom % 32);
      addr = reg_addr(`MC_RAM_BASE, idx);
      if ($urandom % 2 == 0) begin
        wdata = $urandom;
        strb  = 4'($urandom);
        axil_write(addr, wdata, strb, OKAY);
        mask           = lane_mask(strb);
        ram_model[idx] = (ram_model[idx] & ~mask) | (wdata & mask);
        ram_vld[idx]   = ram_vld[idx] | strb;
      end else begin
        axil_read(addr, OKAY, rdata);
        mask = lane_mask(ram_vld[idx]);
        check_data("r_data", rdata & mask, ram_model[idx] & mask);
      end
    end

    // Unmapped accesses leave RAM word 5 alone
    axil_write(reg_addr(`MC_RAM_BASE, 8'd5), 32'hA5C3_0F96, 4'hF, OKAY);
    ram_model[5] = 32'hA5C3_0F96;
    repeat (N_BAD) begin
      // Offset bits aim at word 5 so a leaked write would corrupt it
      addr = $urandom;
      addr[`MC_OFF_W+1:2] = 8'd5;
      while (in_window(addr)) begin
        addr = $urandom;
        addr[`MC_OFF_W+1:2] = 8'd5;
      end
      axil_write(addr, $urandom, 4'hF, DECERR);
      axil_read(addr, DECERR, rdata);
      check_data("r_data", rdata, '0);
    end
    axil_read(reg_addr(`MC_RAM_BASE, 8'd5), OKAY, rdata);
    check_data("r_data", rdata, ram_model[5]);

    repeat (N_CHARS) begin
      ch = 8'($urandom);
      exp_chars.push_back(ch);
      char_cnt = char_cnt + 32'd1;
      axil_write(reg_addr(`MC_SIMCTRL_BASE, `MC_SC_CHAR), {24'($urandom), ch}, 4'($urandom), OKAY);
    end
    axil_read(reg_addr(`MC_SIMCTRL_BASE, `MC_SC_CHAR), OKAY, rdata);
    check_data("r_data", rdata, char_cnt);
    axil_write(reg_addr(`MC_SIMCTRL_BASE, `MC_SC_HALT), 32'h1, 4'hF, OKAY);
    axil_read(reg_addr(`MC_SIMCTRL_BASE, `MC_SC_HALT), OKAY, rdata);
    check_data("r_data", rdata, 32'h1);
    if (!halt) begin
      fail_stop("halt_o stayed low after writing the halt register");
    end

    // Low half of V well below wrap
    v_hi = $urandom & 32'h7FFF_FFFF;
    v_lo = $urandom & 32'h7FFF_FFFF;
    axil_write(reg_addr(`MC_TIMER_BASE, `MC_TM_CMP_HI), '1, 4'hF, OKAY);
    axil_write(reg_addr(`MC_TIMER_BASE, `MC_TM_HI), v_hi, 4'hF, OKAY);
    t0 = cyc;
    axil_write(reg_addr(`MC_TIMER_BASE, `MC_TM_LO), v_lo, 4'hF, OKAY);
    axil_read(reg_addr(`MC_TIMER_BASE, `MC_TM_LO), OKAY, rdata);
    elapsed = cyc - t0;
    if (rdata < v_lo || rdata >= v_lo + elapsed) begin
      fail_stop($sformatf("MISMATCH mtime_lo got 0x%08h expected 0x%08h to 0x%08h",
                          rdata, v_lo, v_lo + elapsed - 1));
    end
    axil_write(reg_addr(`MC_TIMER_BASE, `MC_TM_CMP_LO), v_lo + 32'd100, 4'hF, OKAY);
    axil_write(reg_addr(`MC_TIMER_BASE, `MC_TM_CMP_HI), v_hi, 4'hF, OKAY);
    if (timer_irq) begin
      fail_stop("timer_irq_o high while mtimecmp is still ahead of mtime");
    end
    waited = 0;
    while (!timer_irq && waited < 200) begin
      @(negedge clk_sys);
      waited++;
    end
    if (!timer_irq) begin
      fail_stop("timer_irq_o did not rise within 200 cycles");
    end
    axil_write(reg_addr(`MC_TIMER_BASE, `MC_TM_CMP_HI), '1, 4'hF, OKAY);
    if (timer_irq) begin
      fail_stop("timer_irq_o stayed high after mtimecmp was moved up");
    end

    if (exp_chars.size() != 0) begin
      fail_stop("written characters never appeared on char_o");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== mc_sys_top.f ====
+incdir+.
mc_sys_pkg.sv
mc_bus_fsm.sv
mc_timer.sv
mc_ram.sv
mc_sim_ctrl.sv
mc_sys_top.sv
tb_mc_sys.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mc_sys
FILELIST  ?= mc_sys_top.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulator exits non-zero on $fatal
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
